// File: filelist.f
hw/arcade_pkg.sv
hw/clock_enable_gen.sv
hw/ps2_key_decoder.sv
hw/download_regs.sv
hw/game_input_mapper.sv
hw/arcade_input_top.sv
tests/tb_arcade_input.sv

// File: Makefile
SIM := obj_dir/Vtb_arcade_input

.PHONY: all run clean

all: run

$(SIM): filelist.f $(wildcard hw/*.sv tests/*.sv)
	verilator --binary --timing --assert -j 0 --top-module tb_arcade_input -f filelist.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// File: tests/tb_arcade_input.sv
// Testbench for the input hub: clock enables, joystick, keyboard and download port mapping
`timescale 1ns/1ns
`default_nettype none

module tb_arcade_input;

	import arcade_pkg::*;

	localparam int CPU_RELOAD  = 13;
	localparam int JOY_VECTORS = 10;
	localparam int KEY_EVENTS  = 64;
	localparam int DIP_WRITES  = 30;
	// Reset, enables, 14 game/mode runs, keyboard with repeats, download
	localparam int TEST_CYCLES = 3 + 112 + 14 * (2 + JOY_VECTORS) + KEY_EVENTS * 4 + 4 * 2
		+ 2 + DIP_WRITES * 2 + 3 * 2;
	localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * 40;

	logic                 clk_sys;
	logic                 arst_n;
	key_event_t           key_event;
	joy_t                 joy_1;
	joy_t                 joy_2;
	logic                 dl_wr;
	logic [7:0]           dl_index;
	logic [DL_ADDR_W-1:0] dl_addr;
	logic [7:0]           dl_data;
	logic                 fire_mode_move;
	port_byte_t           port_a, port_b, port_c, port_d;
	hw_sel_t              hw_sel;
	logic                 landscape, four_fire;
	logic                 ce_12, ce_6p, ce_6n, ce_cpu;

	// Reference model state
	player_btn_t m_p1, m_p2;
	logic        m_start_1, m_start_2;
	logic [1:0]  m_coin;              // Two coin keys
	logic [7:0]  m_game;
	port_byte_t  m_dip [4];
	logic [31:0] rng_state;

	arcade_input_top #(.CPU_CE_RELOAD(CPU_RELOAD)) UUT (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("** FAIL **");
		$fatal(1, "Run stopped by the watchdog");
	end

	// ====================================================================
	// Random numbers and tables
	// ====================================================================
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic logic [7:0] kept_game(input int idx);
		case (idx)
			0:       return 8'd0;     // scramble
			1:       return 8'd2;
			2:       return 8'd4;
			3:       return 8'd10;
			4:       return 8'd11;
			5:       return 8'd14;
			default: return 8'd16;    // minefld
		endcase
	endfunction

	// Arrows first, so an index below 4 picks an arrow
	function automatic logic [8:0] table_key(input int idx);
		case (idx)
			0:  return 9'h075;
			1:  return 9'h072;
			2:  return 9'h06B;
			3:  return 9'h074;
			4:  return 9'h014;
			5:  return 9'h029;
			6:  return 9'h005;
			7:  return 9'h016;
			8:  return 9'h006;
			9:  return 9'h01E;
			10: return 9'h02E;
			11: return 9'h036;
			12: return 9'h02D;
			13: return 9'h02B;
			14: return 9'h023;
			15: return 9'h034;
			16: return 9'h01C;
			default: return 9'h01B;
		endcase
	endfunction

	// ====================================================================
	// Reference model
	// ====================================================================
	task automatic model_key(input logic [8:0] code, input logic pressed);
		if (code[7:0] == 8'h75)
			m_p1[3] = pressed;                // Arrows ignore the E0 flag
		else if (code[7:0] == 8'h72)
			m_p1[2] = pressed;
		else if (code[7:0] == 8'h6B)
			m_p1[1] = pressed;
		else if (code[7:0] == 8'h74)
			m_p1[0] = pressed;
		else
		begin
			case (code)
				9'h014:         m_p1[4] = pressed;
				9'h029:         m_p1[5] = pressed;
				9'h005, 9'h016: m_start_1 = pressed;
				9'h006, 9'h01E: m_start_2 = pressed;
				9'h02E:         m_coin[0] = pressed;
				9'h036:         m_coin[1] = pressed;
				9'h02D:         m_p2[3] = pressed;
				9'h02B:         m_p2[2] = pressed;
				9'h023:         m_p2[1] = pressed;
				9'h034:         m_p2[0] = pressed;
				9'h01C:         m_p2[4] = pressed;
				9'h01B:         m_p2[5] = pressed;
				default:
				begin
					// Unknown key
				end
			endcase
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
			$display("** FAIL **");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic check_outputs(input string name);
		player_btn_t b;
		logic        up, dn, lf, rt, fa, fb, fc, fd, fe, s1, s2, cn;
		port_byte_t  act_a, act_b, act_c;
		port_byte_t  exp_a, exp_b, exp_c;
		hw_sel_t     hw;
		logic        land, four;
		b  = m_p1 | m_p2 | joy_1[8:0] | joy_2[8:0];
		rt = b[0];
		lf = b[1];
		dn = b[2];
		up = b[3];
		{fe, fd, fc, fb, fa} = b[8:4];
		s1 = m_start_1 | joy_1[8] | joy_2[8];
		s2 = m_start_2 | joy_1[9] | joy_2[9];
		cn = (|m_coin) | joy_1[10] | joy_2[10];
		hw    = 8'd0;
		land  = 1'b0;
		four  = 1'b0;
		act_a = {cn, 1'b0, lf, rt, fa, 1'b0, fb, up};      // Default layout
		act_b = {s1, s2, lf, rt, fa, fb, 2'b00};
		act_c = {1'b0, dn, 1'b0, up, 3'b000, dn};
		case (m_game)
			8'd2: hw = 8'd1;
			8'd4:
			begin
				hw    = 8'd2;
				act_a = {cn, 1'b0, lf, rt, dn, up, fa, fb};
				act_b = 8'h00;
				act_c = {1'b0, s2, 5'b00000, s1};
			end
			8'd10:
			begin
				hw    = 8'd6;
				act_a = {cn, 1'b0, lf, rt, dn, up, 1'b0, fa};
				act_b = {1'b0, fa, lf, rt, up, dn, 2'b00};
				act_c = {1'b0, s2, 5'b00000, s1};
			end
			8'd11:
			begin
				hw    = 8'd7;
				four  = 1'b1;
				act_a = {cn, 1'b0, lf, rt, dn, up, s1, s2};
				if (fire_mode_move)
					act_b = {1'b0, fe | fa, lf, rt, dn, up, 2'b00};
				else
					act_b = {1'b0, fe, fd, fa, fb, fc, 2'b00};
				act_c = 8'h00;
			end
			8'd14:
			begin
				hw    = 8'd5;
				land  = 1'b1;
				act_c = {fc, dn, fc, up, 3'b000, dn};
			end
			8'd16:
			begin
				hw    = 8'd8;
				four  = 1'b1;
				act_a = {cn, 1'b0, lf, rt, dn, up, 1'b0, s1};
				if (fire_mode_move)
					act_b = {2'b00, lf, rt, dn, up, 2'b00};
				else
					act_b = {2'b00, fd, fa, fb, fc, 2'b00};
				act_c = {1'b0, s2, 5'b00000, s1};
			end
			default:
			begin
				// Scramble and unknown codes
			end
		endcase
		exp_a = ~act_a & m_dip[0];
		exp_b = ~act_b & m_dip[1];
		exp_c = ~act_c & m_dip[2];
		check_value({name, " port_a"}, 32'(exp_a), 32'(port_a));
		check_value({name, " port_b"}, 32'(exp_b), 32'(port_b));
		check_value({name, " port_c"}, 32'(exp_c), 32'(port_c));
		check_value({name, " port_d"}, 32'(m_dip[3]), 32'(port_d));
		check_value({name, " hw_sel"}, 32'(hw), 32'(hw_sel));
		check_value({name, " landscape"}, 32'(land), 32'(landscape));
		check_value({name, " four_fire"}, 32'(four), 32'(four_fire));
	endtask

	// ====================================================================
	// Stimulus, always applied right after a falling edge
	// ====================================================================
	task automatic settle_and_check(input string name, input int edges);
		repeat (edges) @(posedge clk_sys);
		@(negedge clk_sys);
		check_outputs(name);
	endtask

	task automatic download_write(input string name, input logic [7:0] idx,
		input logic [DL_ADDR_W-1:0] addr, input logic [7:0] data);
		dl_wr    = 1'b1;
		dl_index = idx;
		dl_addr  = addr;
		dl_data  = data;
		if (idx == IDX_GAME_SEL)
			m_game = data;
		else if (idx == IDX_DIP && addr < 16'd4)
			m_dip[addr[1:0]] = data;
		@(posedge clk_sys);
		@(negedge clk_sys);
		dl_wr = 1'b0;                     // Single-cycle strobe
		settle_and_check(name, 1);
	endtask

	task automatic send_key(input logic [8:0] code, input logic pressed, input logic flip);
		logic toggle;
		toggle    = key_event[10] ^ flip;
		key_event = {toggle, pressed, code};
		if (flip)
			model_key(code, pressed);
		settle_and_check("keyboard", 2);
	endtask

	task automatic drive_joysticks();
		joy_1 = joy_t'(next_rand() & next_rand());   // Sparse bits
		joy_2 = joy_t'(next_rand() & next_rand());
	endtask

	initial
	begin
		int          n_12, n_6p, n_6n, n_cpu;
		int          last_12, last_6p, last_6n, last_cpu;
		logic [31:0] r;
		logic [8:0]  code;
		logic [7:0]  dl_idx;
		arst_n         = 1'b0;
		key_event      = '0;
		joy_1          = '0;
		joy_2          = '0;
		dl_wr          = 1'b0;
		dl_index       = '0;
		dl_addr        = '0;
		dl_data        = '0;
		fire_mode_move = 1'b0;
		rng_state      = 32'd88947;
		m_p1           = '0;
		m_p2           = '0;
		m_start_1      = 1'b0;
		m_start_2      = 1'b0;
		m_coin         = '0;
		m_game         = 8'd0;
		m_dip          = '{default: 8'hFF};

		// Test 1: reset state
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("reset port_a", 32'hFF, 32'(port_a));
		check_value("reset port_b", 32'hFF, 32'(port_b));
		check_value("reset port_c", 32'hFF, 32'(port_c));
		check_value("reset port_d", 32'hFF, 32'(port_d));
		check_value("reset hw_sel", 0, 32'(hw_sel));
		check_value("reset flags", 0, 32'({landscape, four_fire}));
		check_value("reset clock enables", 0, 32'({ce_12, ce_6p, ce_6n, ce_cpu}));
		arst_n = 1'b1;

		// Test 2: clock enables over 112 cycles
		n_12 = 0;
		n_6p = 0;
		n_6n = 0;
		n_cpu = 0;
		last_12 = -1;
		last_6p = -1;
		last_6n = -1;
		last_cpu = -1;
		for (int i = 0; i < 112; i++)
		begin
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_value("ce_6p with ce_6n", 0, 32'(ce_6p & ce_6n));
			check_value("ce_6 without ce_12", 0, 32'((ce_6p | ce_6n) & ~ce_12));
			if (ce_12)
			begin
				if (last_12 >= 0)
					check_value("ce_12 spacing", 2, 32'(i - last_12));
				last_12 = i;
				n_12++;
			end
			if (ce_6p)
			begin
				if (last_6p >= 0)
					check_value("ce_6p spacing", 4, 32'(i - last_6p));
				last_6p = i;
				n_6p++;
			end
			if (ce_6n)
			begin
				if (last_6n >= 0)
					check_value("ce_6n spacing", 4, 32'(i - last_6n));
				last_6n = i;
				n_6n++;
			end
			if (ce_cpu)
			begin
				if (last_cpu >= 0)
					check_value("ce_cpu spacing", CPU_RELOAD + 1, 32'(i - last_cpu));
				last_cpu = i;
				n_cpu++;
			end
		end
		check_value("ce_12 count", 56, 32'(n_12));
		check_value("ce_6p count", 28, 32'(n_6p));
		check_value("ce_6n count", 28, 32'(n_6n));
		check_value("ce_cpu count", 112 / (CPU_RELOAD + 1), 32'(n_cpu));

		// Test 3: joystick mapping per game and fire mode
		for (int g = 0; g < 7; g++)
		begin
			for (int mode = 0; mode < 2; mode++)
			begin
				fire_mode_move = mode[0];
				download_write("joystick game", IDX_GAME_SEL, '0, kept_game(g));
				for (int v = 0; v < JOY_VECTORS; v++)
				begin
					drive_joysticks();
					settle_and_check("joystick", 1);
				end
			end
		end

		// Test 4: keyboard events with idle sticks
		joy_1 = '0;
		joy_2 = '0;
		for (int i = 0; i < KEY_EVENTS; i++)
		begin
			if (i % 16 == 0)
			begin
				fire_mode_move = next_rand() % 2 == 1;
				download_write("keyboard game", IDX_GAME_SEL, '0, kept_game(next_rand() % 7));
			end
			r = next_rand();
			case (r[2:0])
				3'd5:    code = r[24:16];                        // Mostly unmapped
				3'd6:    code = table_key(r[31:16] % 4) | 9'h100; // Extended arrow
				default: code = table_key(r[31:16] % 18);
			endcase
			send_key(code, r[4], r[2:0] != 3'd7);    // Code 7 keeps the toggle
			if (r[3])
				send_key(code, r[4], 1'b1);
		end

		// Test 5: DIP banks, other indices and unknown games
		download_write("download game", IDX_GAME_SEL, '0, kept_game(next_rand() % 7));
		for (int i = 0; i < DIP_WRITES; i++)
		begin
			r = next_rand();
			drive_joysticks();
			if (r[1:0] == 2'd3)
				dl_idx = r[15:8];
			else
				dl_idx = IDX_DIP;
			download_write("download", dl_idx, 16'(r[18:16]), r[31:24]);
		end
		download_write("unknown game", IDX_GAME_SEL, 16'h0007, 8'd3);
		download_write("unknown game", IDX_GAME_SEL, 16'h0000, 8'd21);
		download_write("unknown game", IDX_GAME_SEL, 16'h0100, 8'hFF);

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/arcade_input_top.sv
// Player-input hub top level with clock enables, keyboard, download and port mapping
`timescale 1ns/1ns
`default_nettype none

module arcade_input_top
#(
	parameter int CPU_CE_RELOAD = 13    // About 1.79 MHz CPU enable
)
(
	input  wire logic                              clk_sys,
	input  wire logic                              arst_n,
	input  wire arcade_pkg::key_event_t            key_event,
	input  wire arcade_pkg::joy_t                  joy_1,
	input  wire arcade_pkg::joy_t                  joy_2,
	input  wire logic                              dl_wr,
	input  wire logic [7:0]                        dl_index,
	input  wire logic [arcade_pkg::DL_ADDR_W-1:0]  dl_addr,
	input  wire logic [7:0]                        dl_data,
	input  wire logic                              fire_mode_move,
	output arcade_pkg::port_byte_t                 port_a,
	output arcade_pkg::port_byte_t                 port_b,
	output arcade_pkg::port_byte_t                 port_c,
	output arcade_pkg::port_byte_t                 port_d,
	output arcade_pkg::hw_sel_t                    hw_sel,
	output logic                                   landscape,
	output logic                                   four_fire,
	output logic                                   ce_12,
	output logic                                   ce_6p,
	output logic                                   ce_6n,
	output logic                                   ce_cpu
);

	import arcade_pkg::*;

	player_btn_t kbd_p1;
	player_btn_t kbd_p2;
	logic        kbd_start_1;
	logic        kbd_start_2;
	logic        kbd_coin;
	game_e       game;
	port_byte_t  dip_a, dip_b, dip_c, dip_d;

	clock_enable_gen #(.CPU_CE_RELOAD(CPU_CE_RELOAD)) u_clock_enable_gen (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.ce_12   (ce_12),
		.ce_6p   (ce_6p),
		.ce_6n   (ce_6n),
		.ce_cpu  (ce_cpu)
	);

	ps2_key_decoder u_ps2_key_decoder (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.key_event   (key_event),
		.kbd_p1      (kbd_p1),
		.kbd_p2      (kbd_p2),
		.kbd_start_1 (kbd_start_1),
		.kbd_start_2 (kbd_start_2),
		.kbd_coin    (kbd_coin)
	);

	download_regs u_download_regs (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.dl_wr    (dl_wr),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.game     (game),
		.dip_a    (dip_a),
		.dip_b    (dip_b),
		.dip_c    (dip_c),
		.dip_d    (dip_d)
	);

	game_input_mapper u_game_input_mapper (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.game           (game),
		.kbd_p1         (kbd_p1),
		.kbd_p2         (kbd_p2),
		.kbd_start_1    (kbd_start_1),
		.kbd_start_2    (kbd_start_2),
		.kbd_coin       (kbd_coin),
		.joy_1          (joy_1),
		.joy_2          (joy_2),
		.fire_mode_move (fire_mode_move),
		.dip_a          (dip_a),
		.dip_b          (dip_b),
		.dip_c          (dip_c),
		.dip_d          (dip_d),
		.port_a         (port_a),
		.port_b         (port_b),
		.port_c         (port_c),
		.port_d         (port_d),
		.hw_sel         (hw_sel),
		.landscape      (landscape),
		.four_fire      (four_fire)
	);

endmodule

`default_nettype wire

// File: hw/game_input_mapper.sv
// Merges player controls and builds the per-game input port bytes and flags
`timescale 1ns/1ns
`default_nettype none

module game_input_mapper
(
	input  wire logic                     clk_sys,
	input  wire logic                     arst_n,
	input  wire arcade_pkg::game_e        game,
	input  wire arcade_pkg::player_btn_t  kbd_p1,
	input  wire arcade_pkg::player_btn_t  kbd_p2,
	input  wire logic                     kbd_start_1,
	input  wire logic                     kbd_start_2,
	input  wire logic                     kbd_coin,
	input  wire arcade_pkg::joy_t         joy_1,
	input  wire arcade_pkg::joy_t         joy_2,
	input  wire logic                     fire_mode_move,
	input  wire arcade_pkg::port_byte_t   dip_a,
	input  wire arcade_pkg::port_byte_t   dip_b,
	input  wire arcade_pkg::port_byte_t   dip_c,
	input  wire arcade_pkg::port_byte_t   dip_d,
	output arcade_pkg::port_byte_t        port_a,
	output arcade_pkg::port_byte_t        port_b,
	output arcade_pkg::port_byte_t        port_c,
	output arcade_pkg::port_byte_t        port_d,
	output arcade_pkg::hw_sel_t           hw_sel,
	output logic                          landscape,
	output logic                          four_fire
);

	import arcade_pkg::*;

	player_btn_t btn;
	logic        m_up, m_down, m_left, m_right;
	logic        m_fire_a, m_fire_b, m_fire_c, m_fire_d, m_fire_e;
	logic        m_start_1, m_start_2, m_coin;
	port_byte_t  act_a;             // Active-high lists, inverted on the way out
	port_byte_t  act_b;
	port_byte_t  act_c;
	hw_sel_t     hw_sel_d;
	logic        landscape_d;
	logic        four_fire_d;

	// ====================================================================
	// Control merge, both players and both sources
	// ====================================================================
	assign btn = kbd_p1 | kbd_p2 | joy_1[$bits(player_btn_t)-1:0]
		| joy_2[$bits(player_btn_t)-1:0];

	assign m_up      = btn[BTN_UP];
	assign m_down    = btn[BTN_DOWN];
	assign m_left    = btn[BTN_LEFT];
	assign m_right   = btn[BTN_RIGHT];
	assign m_fire_a  = btn[BTN_FIRE_A];
	assign m_fire_b  = btn[BTN_FIRE_B];
	assign m_fire_c  = btn[BTN_FIRE_C];
	assign m_fire_d  = btn[BTN_FIRE_D];
	assign m_fire_e  = btn[BTN_FIRE_E];
	assign m_start_1 = kbd_start_1 | joy_1[JOY_START_1] | joy_2[JOY_START_1];
	assign m_start_2 = kbd_start_2 | joy_1[JOY_START_2] | joy_2[JOY_START_2];
	assign m_coin    = kbd_coin | joy_1[JOY_COIN] | joy_2[JOY_COIN];

	// ====================================================================
	// Per-game layout
	// ====================================================================
	always_comb
	begin
		// Scramble layout, also the fallback for unknown codes
		hw_sel_d    = '0;
		landscape_d = 1'b0;
		four_fire_d = 1'b0;
		act_a = {m_coin, 1'b0, m_left, m_right, m_fire_a, 1'b0, m_fire_b, m_up};
		act_b = {m_start_1, m_start_2, m_left, m_right, m_fire_a, m_fire_b, 2'b00};
		act_c = {1'b0, m_down, 1'b0, m_up, 3'b000, m_down};

		case (game)
			GAME_FROGGER:
				hw_sel_d = 8'd1;
			GAME_TAZMAN:
			begin
				hw_sel_d = 8'd2;
				act_a = {m_coin, 1'b0, m_left, m_right, m_down, m_up, m_fire_a, m_fire_b};
				act_b = '0;
				act_c = {1'b0, m_start_2, 5'b00000, m_start_1};
			end
			GAME_ANTEATER:
			begin
				hw_sel_d = 8'd6;
				act_a = {m_coin, 1'b0, m_left, m_right, m_down, m_up, 1'b0, m_fire_a};
				act_b = {1'b0, m_fire_a, m_left, m_right, m_up, m_down, 2'b00};
				act_c = {1'b0, m_start_2, 5'b00000, m_start_1};
			end
			GAME_LOSTTOMB:
			begin
				hw_sel_d    = 8'd7;
				four_fire_d = 1'b1;
				act_a = {m_coin, 1'b0, m_left, m_right, m_down, m_up, m_start_1, m_start_2};
				if (fire_mode_move)
					act_b = {1'b0, m_fire_e | m_fire_a, m_left, m_right, m_down, m_up, 2'b00};
				else
					act_b = {1'b0, m_fire_e, m_fire_d, m_fire_a, m_fire_b, m_fire_c, 2'b00};
				act_c = '0;
			end
			GAME_STRATGYX:
			begin
				hw_sel_d    = 8'd5;
				landscape_d = 1'b1;
				act_c = {m_fire_c, m_down, m_fire_c, m_up, 3'b000, m_down};
			end
			GAME_MINEFLD:
			begin
				hw_sel_d    = 8'd8;
				four_fire_d = 1'b1;
				act_a = {m_coin, 1'b0, m_left, m_right, m_down, m_up, 1'b0, m_start_1};
				if (fire_mode_move)
					act_b = {2'b00, m_left, m_right, m_down, m_up, 2'b00};
				else
					act_b = {2'b00, m_fire_d, m_fire_a, m_fire_b, m_fire_c, 2'b00};
				act_c = {1'b0, m_start_2, 5'b00000, m_start_1};
			end
			default:
			begin
				// Keep the scramble layout
			end
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			port_a    <= '1;
			port_b    <= '1;
			port_c    <= '1;
			port_d    <= '1;
			hw_sel    <= '0;
			landscape <= 1'b0;
			four_fire <= 1'b0;
		end
		else
		begin
			port_a    <= ~act_a & dip_a;
			port_b    <= ~act_b & dip_b;
			port_c    <= ~act_c & dip_c;
			port_d    <= dip_d;          // No controls on port D
			hw_sel    <= hw_sel_d;
			landscape <= landscape_d;
			four_fire <= four_fire_d;
		end
	end

	// Flag follows the game seen one edge earlier
	a_landscape_game: assert property (@(posedge clk_sys) disable iff (!arst_n)
		landscape |-> ($past(game) == GAME_STRATGYX));

endmodule

`default_nettype wire

// File: hw/download_regs.sv
// Game-select byte and DIP banks loaded through the download port
`timescale 1ns/1ns
`default_nettype none

module download_regs
(
	input  wire logic                              clk_sys,
	input  wire logic                              arst_n,
	input  wire logic                              dl_wr,
	input  wire logic [7:0]                        dl_index,
	input  wire logic [arcade_pkg::DL_ADDR_W-1:0]  dl_addr,
	input  wire logic [7:0]                        dl_data,
	output arcade_pkg::game_e                      game,
	output arcade_pkg::port_byte_t                 dip_a,
	output arcade_pkg::port_byte_t                 dip_b,
	output arcade_pkg::port_byte_t                 dip_c,
	output arcade_pkg::port_byte_t                 dip_d
);

	import arcade_pkg::*;

	localparam int DIP_SEL_W = $clog2(DIP_BANKS);

	logic       wr_game;
	logic       wr_dip;
	game_e      game_q;
	port_byte_t dip_q [DIP_BANKS];

	// Game write ignores the address
	assign wr_game = dl_wr && (dl_index == IDX_GAME_SEL);
	assign wr_dip  = dl_wr && (dl_index == IDX_DIP) && (dl_addr < DL_ADDR_W'(DIP_BANKS));

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			game_q <= GAME_SCRAMBLE;
			dip_q  <= '{default: '1};      // All switches open
		end
		else
		begin
			if (wr_game)
				game_q <= game_e'(dl_data);   // Unknown codes kept as is
			if (wr_dip)
				dip_q[dl_addr[DIP_SEL_W-1:0]] <= dl_data;
		end
	end

	assign game  = game_q;
	assign dip_a = dip_q[0];
	assign dip_b = dip_q[1];
	assign dip_c = dip_q[2];
	assign dip_d = dip_q[3];

	a_index_known: assert property (@(posedge clk_sys) disable iff (!arst_n)
		dl_wr |-> !$isunknown(dl_index));

endmodule

`default_nettype wire

// File: hw/ps2_key_decoder.sv
// PS/2 key events to held button states for two players
`timescale 1ns/1ns
`default_nettype none

module ps2_key_decoder
(
	input  wire logic                    clk_sys,
	input  wire logic                    arst_n,
	input  wire arcade_pkg::key_event_t  key_event,
	output arcade_pkg::player_btn_t      kbd_p1,
	output arcade_pkg::player_btn_t      kbd_p2,
	output logic                         kbd_start_1,
	output logic                         kbd_start_2,
	output logic                         kbd_coin
);

	import arcade_pkg::*;

	logic        toggle_q;          // Toggle bit as seen last cycle
	logic        new_event;
	logic        pressed;
	logic [8:0]  code;
	player_btn_t p1_q;
	player_btn_t p2_q;
	logic        start_1_q;
	logic        start_2_q;
	logic [1:0]  coin_q;            // Two separate coin keys

	assign new_event = key_event[KEY_TOGGLE] ^ toggle_q;
	assign pressed   = key_event[KEY_PRESSED];
	assign code      = key_event[8:0];

	// ====================================================================
	// Button state, updated on each toggle change
	// ====================================================================
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			toggle_q  <= 1'b0;
			p1_q      <= '0;
			p2_q      <= '0;
			start_1_q <= 1'b0;
			start_2_q <= 1'b0;
			coin_q    <= '0;
		end
		else
		begin
			toggle_q <= key_event[KEY_TOGGLE];
			if (new_event)
			begin
				casez (code)
					// Arrows accept the extended prefix
					{1'b?, KEY_ARROW_UP[7:0]}:    p1_q[BTN_UP]    <= pressed;
					{1'b?, KEY_ARROW_DOWN[7:0]}:  p1_q[BTN_DOWN]  <= pressed;
					{1'b?, KEY_ARROW_LEFT[7:0]}:  p1_q[BTN_LEFT]  <= pressed;
					{1'b?, KEY_ARROW_RIGHT[7:0]}: p1_q[BTN_RIGHT] <= pressed;
					KEY_LCTRL:                    p1_q[BTN_FIRE_A] <= pressed;
					KEY_SPACE:                    p1_q[BTN_FIRE_B] <= pressed;

					KEY_F1, KEY_1:                start_1_q <= pressed;
					KEY_F2, KEY_2:                start_2_q <= pressed;
					KEY_5:                        coin_q[0] <= pressed;
					KEY_6:                        coin_q[1] <= pressed;

					// Second player, MAME style layout
					KEY_R:                        p2_q[BTN_UP]     <= pressed;
					KEY_F:                        p2_q[BTN_DOWN]   <= pressed;
					KEY_D:                        p2_q[BTN_LEFT]   <= pressed;
					KEY_G:                        p2_q[BTN_RIGHT]  <= pressed;
					KEY_A:                        p2_q[BTN_FIRE_A] <= pressed;
					KEY_S:                        p2_q[BTN_FIRE_B] <= pressed;
					default:
					begin
						// Unmapped key, state kept
					end
				endcase
			end
		end
	end

	assign kbd_p1      = p1_q;
	assign kbd_p2      = p2_q;
	assign kbd_start_1 = start_1_q;
	assign kbd_start_2 = start_2_q;
	assign kbd_coin    = |coin_q;

endmodule

`default_nettype wire

// File: hw/clock_enable_gen.sv
// Pixel and CPU clock-enable strobes derived from the system clock
`timescale 1ns/1ns
`default_nettype none

module clock_enable_gen
#(
	parameter int CPU_CE_RELOAD = 13
)
(
	input  wire logic clk_sys,
	input  wire logic arst_n,
	output logic      ce_12,
	output logic      ce_6p,
	output logic      ce_6n,
	output logic      ce_cpu
);

	localparam int CPU_CNT_W = $clog2(CPU_CE_RELOAD + 1);

	logic [1:0]           div_q;      // Free-running pixel divider
	logic [CPU_CNT_W-1:0] cpu_cnt_q;

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			div_q     <= '0;
			cpu_cnt_q <= '0;
			ce_12     <= 1'b0;
			ce_6p     <= 1'b0;
			ce_6n     <= 1'b0;
			ce_cpu    <= 1'b0;
		end
		else
		begin
			div_q <= div_q + 2'd1;
			ce_12 <= div_q[0];
			ce_6p <= div_q[0] & ~div_q[1];   // Rising half of the 6 MHz phase
			ce_6n <= div_q[0] &  div_q[1];

			// Reload at zero, one strobe per CPU_CE_RELOAD+1 cycles
			ce_cpu <= (cpu_cnt_q == '0);
			if (cpu_cnt_q == '0)
				cpu_cnt_q <= CPU_CNT_W'(CPU_CE_RELOAD);
			else
				cpu_cnt_q <= cpu_cnt_q - CPU_CNT_W'(1);
		end
	end

	a_ce6_exclusive: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(ce_6p && ce_6n));
	a_ce6_within_ce12: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(ce_6p || ce_6n) |-> ce_12);

endmodule

`default_nettype wire

// File: hw/arcade_pkg.sv
// Game codes, download indices, PS/2 scan codes and control types for the input hub
`default_nettype none

package arcade_pkg;

	// ====================================================================
	// Game selection and per-game output types
	// ====================================================================
	typedef enum logic [7:0] {
		GAME_SCRAMBLE = 8'd0,
		GAME_FROGGER  = 8'd2,
		GAME_TAZMAN   = 8'd4,
		GAME_ANTEATER = 8'd10,
		GAME_LOSTTOMB = 8'd11,
		GAME_STRATGYX = 8'd14,
		GAME_MINEFLD  = 8'd16
	} game_e;

	typedef logic [7:0]  hw_sel_t;
	typedef logic [7:0]  port_byte_t;     // Active low towards the game
	typedef logic [8:0]  player_btn_t;
	typedef logic [15:0] joy_t;
	typedef logic [10:0] key_event_t;

	// Button bits, shared by player_btn_t and the low joystick bits
	localparam int BTN_RIGHT  = 0;
	localparam int BTN_LEFT   = 1;
	localparam int BTN_DOWN   = 2;
	localparam int BTN_UP     = 3;
	localparam int BTN_FIRE_A = 4;
	localparam int BTN_FIRE_B = 5;
	localparam int BTN_FIRE_C = 6;
	localparam int BTN_FIRE_D = 7;
	localparam int BTN_FIRE_E = 8;      // Doubles as start 1 on a stick

	// Joystick-only bits
	localparam int JOY_START_1 = 8;
	localparam int JOY_START_2 = 9;
	localparam int JOY_COIN    = 10;

	// ====================================================================
	// Download port
	// ====================================================================
	localparam int         DL_ADDR_W    = 16;
	localparam logic [7:0] IDX_GAME_SEL = 8'd1;
	localparam logic [7:0] IDX_DIP      = 8'd254;
	localparam int         DIP_BANKS    = 4;

	// ====================================================================
	// PS/2 events and scan codes
	// ====================================================================
	localparam int KEY_TOGGLE  = 10;
	localparam int KEY_PRESSED = 9;

	localparam logic [8:0] KEY_ARROW_UP    = 9'h075;   // Matched without the E0 flag
	localparam logic [8:0] KEY_ARROW_DOWN  = 9'h072;
	localparam logic [8:0] KEY_ARROW_LEFT  = 9'h06B;
	localparam logic [8:0] KEY_ARROW_RIGHT = 9'h074;
	localparam logic [8:0] KEY_LCTRL       = 9'h014;
	localparam logic [8:0] KEY_SPACE       = 9'h029;
	localparam logic [8:0] KEY_F1          = 9'h005;
	localparam logic [8:0] KEY_F2          = 9'h006;
	localparam logic [8:0] KEY_1           = 9'h016;
	localparam logic [8:0] KEY_2           = 9'h01E;
	localparam logic [8:0] KEY_5           = 9'h02E;
	localparam logic [8:0] KEY_6           = 9'h036;
	localparam logic [8:0] KEY_R           = 9'h02D;
	localparam logic [8:0] KEY_F           = 9'h02B;
	localparam logic [8:0] KEY_D           = 9'h023;
	localparam logic [8:0] KEY_G           = 9'h034;
	localparam logic [8:0] KEY_A           = 9'h01C;
	localparam logic [8:0] KEY_S           = 9'h01B;

endpackage

`default_nettype wire
